// ==== hw/rv_cfg.svh ====
// rv execute subsystem configuration: data, pc and register file sizes
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and pc width
`define XLEN 32

// rv32e register file
`define REG_AW 4
`define NUM_REGS 16

`endif

// ==== hw/rv_pkg.sv ====
// rv execute subsystem package: alu operation and control-flow kind encodings
package rv_pkg;

    // alu operation selected by decode
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // lui passes the immediate through
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // control-flow kind, none for plain alu instructions
    typedef enum logic [3:0] {
        JMP_NONE = 4'd0,
        JMP_JAL  = 4'd1,
        JMP_JALR = 4'd2,
        JMP_BEQ  = 4'd3,
        JMP_BNE  = 4'd4,
        JMP_BLT  = 4'd5,
        JMP_BGE  = 4'd6,
        JMP_BLTU = 4'd7,
        JMP_BGEU = 4'd8
    } jump_e;

endpackage

// ==== hw/decode_unit.sv ====
// decode unit: rv32e register file with retire forwarding and instruction decode
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_unit import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [31:0]         instr_i,
    input  logic                wb_en_i,
    input  logic [`REG_AW-1:0]  wb_addr_i,
    input  logic [`XLEN-1:0]    wb_data_i,
    input  logic                in_ready_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output logic [`XLEN-1:0]    pc_o,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`XLEN-1:0]    rs1_data_o,
    output logic [`XLEN-1:0]    rs2_data_o,
    output alu_op_e             alu_op_o,
    output jump_e               jump_o,
    output logic                src_a_pc_o,
    output logic                src_b_imm_o,
    output logic                gpr_write_o,
    output logic [`REG_AW-1:0]  rd_o
);

    // major opcodes handled here
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    logic [`XLEN-1:0]   regs [`NUM_REGS];
    opcode_e            opcode;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;
    alu_op_e            f3_alu_op;

    // handshake passes straight through
    assign in_ready_o  = in_ready_i;
    assign out_valid_o = in_valid_i;
    assign pc_o        = pc_i;

    assign opcode   = opcode_e'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign rs1_addr = instr_i[15 +: `REG_AW];
    assign rs2_addr = instr_i[20 +: `REG_AW];
    assign rd_o     = instr_i[7 +: `REG_AW];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'd0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // written at the retire handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // x0 reads zero, retiring result bypasses the array
    assign rs1_data_o = (rs1_addr == '0) ? '0 :
                        (wb_en_i && wb_addr_i == rs1_addr) ? wb_data_i : regs[rs1_addr];
    assign rs2_data_o = (rs2_addr == '0) ? '0 :
                        (wb_en_i && wb_addr_i == rs2_addr) ? wb_data_i : regs[rs2_addr];

    // shared funct3 map for op and op-imm
    always_comb begin
        case (funct3)
            3'b000:  f3_alu_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  f3_alu_op = ALU_SLL;
            3'b010:  f3_alu_op = ALU_SLT;
            3'b011:  f3_alu_op = ALU_SLTU;
            3'b100:  f3_alu_op = ALU_XOR;
            3'b101:  f3_alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  f3_alu_op = ALU_OR;
            default: f3_alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;
        jump_o      = JMP_NONE;
        src_a_pc_o  = 1'b0;
        src_b_imm_o = 1'b0;
        gpr_write_o = 1'b0;
        imm_o       = imm_i;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = f3_alu_op;
                gpr_write_o = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op_o    = f3_alu_op;
                src_b_imm_o = 1'b1;
                gpr_write_o = 1'b1;
            end
            OPC_LUI: begin
                alu_op_o    = ALU_PASS_B;
                src_b_imm_o = 1'b1;
                gpr_write_o = 1'b1;
                imm_o       = imm_u;
            end
            OPC_AUIPC: begin
                src_a_pc_o  = 1'b1;
                src_b_imm_o = 1'b1;
                gpr_write_o = 1'b1;
                imm_o       = imm_u;
            end
            OPC_JAL: begin
                jump_o      = JMP_JAL;
                gpr_write_o = 1'b1;
                imm_o       = imm_j;
            end
            OPC_JALR: begin
                jump_o      = JMP_JALR;
                gpr_write_o = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o = imm_b;
                case (funct3)
                    3'b000:  jump_o = JMP_BEQ;
                    3'b001:  jump_o = JMP_BNE;
                    3'b100:  jump_o = JMP_BLT;
                    3'b101:  jump_o = JMP_BGE;
                    3'b110:  jump_o = JMP_BLTU;
                    3'b111:  jump_o = JMP_BGEU;
                    default: jump_o = JMP_NONE;
                endcase
            end
            // store is not executed, only its immediate format is decoded
            OPC_STORE: imm_o = imm_s;
            default: ;
        endcase
    end

    // execute never writes back to x0
    a_wb_not_x0: assert property (@(posedge clk) disable iff (reset)
        wb_en_i |-> wb_addr_i != '0)
        else $error("writeback to x0");

endmodule

// ==== hw/id_exe_reg.sv ====
// id/exe pipeline register holding one decoded instruction with valid/ready and flush
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_exe_reg import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush_i,
    input  logic                in_valid_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    input  logic [`XLEN-1:0]    rs2_data_i,
    input  alu_op_e             alu_op_i,
    input  jump_e               jump_i,
    input  logic                src_a_pc_i,
    input  logic                src_b_imm_i,
    input  logic                gpr_write_i,
    input  logic [`REG_AW-1:0]  rd_i,
    input  logic                out_ready_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output logic [`XLEN-1:0]    pc_o,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`XLEN-1:0]    rs1_data_o,
    output logic [`XLEN-1:0]    rs2_data_o,
    output alu_op_e             alu_op_o,
    output jump_e               jump_o,
    output logic                src_a_pc_o,
    output logic                src_b_imm_o,
    output logic                gpr_write_o,
    output logic [`REG_AW-1:0]  rd_o
);

    // accept when empty or the held entry leaves this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_o <= 1'b0;
            pc_o        <= '0;
            imm_o       <= '0;
            rs1_data_o  <= '0;
            rs2_data_o  <= '0;
            alu_op_o    <= ALU_ADD;
            jump_o      <= JMP_NONE;
            src_a_pc_o  <= 1'b0;
            src_b_imm_o <= 1'b0;
            gpr_write_o <= 1'b0;
            rd_o        <= '0;
        end else if (flush_i) begin
            // wrong-path instruction at the input is dropped too
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
            if (in_valid_i) begin
                pc_o        <= pc_i;
                imm_o       <= imm_i;
                rs1_data_o  <= rs1_data_i;
                rs2_data_o  <= rs2_data_i;
                alu_op_o    <= alu_op_i;
                jump_o      <= jump_i;
                src_a_pc_o  <= src_a_pc_i;
                src_b_imm_o <= src_b_imm_i;
                gpr_write_o <= gpr_write_i;
                rd_o        <= rd_i;
            end
        end
    end

    // stalled entry must not change under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid_o && !out_ready_i |=> out_valid_o &&
            $stable({pc_o, imm_o, rs1_data_o, rs2_data_o, alu_op_o, jump_o,
                     src_a_pc_o, src_b_imm_o, gpr_write_o, rd_o}))
        else $error("id/exe payload changed while stalled");

    // flush only comes from a held entry retiring
    a_flush_clears: assert property (@(posedge clk) disable iff (reset)
        flush_i |-> out_valid_o ##1 !out_valid_o)
        else $error("id/exe flush without a held entry or valid after flush");

endmodule

// ==== hw/exe_unit.sv ====
// execute unit with alu, branch and jump resolution, redirect and retirement writeback
`timescale 1ns/1ps
`include "rv_cfg.svh"

module exe_unit import rv_pkg::*; (
    input  logic                in_valid_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [`XLEN-1:0]    imm_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    input  logic [`XLEN-1:0]    rs2_data_i,
    input  alu_op_e             alu_op_i,
    input  jump_e               jump_i,
    input  logic                src_a_pc_i,
    input  logic                src_b_imm_i,
    input  logic                gpr_write_i,
    input  logic [`REG_AW-1:0]  rd_i,
    input  logic                retire_ready_i,
    output logic                in_ready_o,
    output logic                retire_valid_o,
    output logic [`XLEN-1:0]    retire_pc_o,
    output logic                retire_we_o,
    output logic [`REG_AW-1:0]  retire_rd_o,
    output logic [`XLEN-1:0]    retire_data_o,
    output logic                redirect_o,
    output logic [`XLEN-1:0]    redirect_pc_o,
    output logic                wb_en_o,
    output logic [`REG_AW-1:0]  wb_addr_o,
    output logic [`XLEN-1:0]    wb_data_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic             is_jump;
    logic             taken;
    logic             retire_fire;
    logic [`XLEN-1:0] jalr_sum;

    assign op_a  = src_a_pc_i ? pc_i : rs1_data_i;
    assign op_b  = src_b_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branch compares always use the register values
    always_comb begin
        case (jump_i)
            JMP_JAL,
            JMP_JALR: taken = 1'b1;
            JMP_BEQ:  taken = rs1_data_i == rs2_data_i;
            JMP_BNE:  taken = rs1_data_i != rs2_data_i;
            JMP_BLT:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            JMP_BGE:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            JMP_BLTU: taken = rs1_data_i < rs2_data_i;
            JMP_BGEU: taken = rs1_data_i >= rs2_data_i;
            default:  taken = 1'b0;
        endcase
    end

    assign is_jump  = (jump_i == JMP_JAL) || (jump_i == JMP_JALR);
    assign jalr_sum = rs1_data_i + imm_i;

    assign in_ready_o     = retire_ready_i;
    assign retire_valid_o = in_valid_i;
    assign retire_fire    = in_valid_i && retire_ready_i;

    assign retire_pc_o   = pc_i;
    assign retire_rd_o   = rd_i;
    assign retire_we_o   = gpr_write_i && (rd_i != '0);
    // link value for jumps
    assign retire_data_o = is_jump ? pc_i + `XLEN'd4 : alu_res;

    assign redirect_o    = retire_fire && taken;
    assign redirect_pc_o = (jump_i == JMP_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign wb_en_o   = retire_fire && retire_we_o;
    assign wb_addr_o = rd_i;
    assign wb_data_o = retire_data_o;

endmodule

// ==== hw/exe_top.sv ====
// execute subsystem top: decode, id/exe register and execute joined by wires
`timescale 1ns/1ps
`include "rv_cfg.svh"

module exe_top import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [31:0]         instr_i,
    input  logic                retire_ready_i,
    output logic                in_ready_o,
    output logic                retire_valid_o,
    output logic [`XLEN-1:0]    retire_pc_o,
    output logic                retire_we_o,
    output logic [`REG_AW-1:0]  retire_rd_o,
    output logic [`XLEN-1:0]    retire_data_o,
    output logic                redirect_o,
    output logic [`XLEN-1:0]    redirect_pc_o
);

    // decode side of the pipeline register
    logic               dec_valid;
    logic               dec_ready;
    logic [`XLEN-1:0]   dec_pc;
    logic [`XLEN-1:0]   dec_imm;
    logic [`XLEN-1:0]   dec_rs1_data;
    logic [`XLEN-1:0]   dec_rs2_data;
    alu_op_e            dec_alu_op;
    jump_e              dec_jump;
    logic               dec_src_a_pc;
    logic               dec_src_b_imm;
    logic               dec_gpr_write;
    logic [`REG_AW-1:0] dec_rd;

    // execute side
    logic               exe_valid;
    logic               exe_ready;
    logic [`XLEN-1:0]   exe_pc;
    logic [`XLEN-1:0]   exe_imm;
    logic [`XLEN-1:0]   exe_rs1_data;
    logic [`XLEN-1:0]   exe_rs2_data;
    alu_op_e            exe_alu_op;
    jump_e              exe_jump;
    logic               exe_src_a_pc;
    logic               exe_src_b_imm;
    logic               exe_gpr_write;
    logic [`REG_AW-1:0] exe_rd;

    logic               wb_en;
    logic [`REG_AW-1:0] wb_addr;
    logic [`XLEN-1:0]   wb_data;

    decode_unit i_decode (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .wb_en_i     (wb_en),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .in_ready_i  (dec_ready),
        .in_ready_o  (in_ready_o),
        .out_valid_o (dec_valid),
        .pc_o        (dec_pc),
        .imm_o       (dec_imm),
        .rs1_data_o  (dec_rs1_data),
        .rs2_data_o  (dec_rs2_data),
        .alu_op_o    (dec_alu_op),
        .jump_o      (dec_jump),
        .src_a_pc_o  (dec_src_a_pc),
        .src_b_imm_o (dec_src_b_imm),
        .gpr_write_o (dec_gpr_write),
        .rd_o        (dec_rd)
    );

    id_exe_reg i_id_exe (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (redirect_o),
        .in_valid_i  (dec_valid),
        .pc_i        (dec_pc),
        .imm_i       (dec_imm),
        .rs1_data_i  (dec_rs1_data),
        .rs2_data_i  (dec_rs2_data),
        .alu_op_i    (dec_alu_op),
        .jump_i      (dec_jump),
        .src_a_pc_i  (dec_src_a_pc),
        .src_b_imm_i (dec_src_b_imm),
        .gpr_write_i (dec_gpr_write),
        .rd_i        (dec_rd),
        .out_ready_i (exe_ready),
        .in_ready_o  (dec_ready),
        .out_valid_o (exe_valid),
        .pc_o        (exe_pc),
        .imm_o       (exe_imm),
        .rs1_data_o  (exe_rs1_data),
        .rs2_data_o  (exe_rs2_data),
        .alu_op_o    (exe_alu_op),
        .jump_o      (exe_jump),
        .src_a_pc_o  (exe_src_a_pc),
        .src_b_imm_o (exe_src_b_imm),
        .gpr_write_o (exe_gpr_write),
        .rd_o        (exe_rd)
    );

    exe_unit i_exe (
        .in_valid_i     (exe_valid),
        .pc_i           (exe_pc),
        .imm_i          (exe_imm),
        .rs1_data_i     (exe_rs1_data),
        .rs2_data_i     (exe_rs2_data),
        .alu_op_i       (exe_alu_op),
        .jump_i         (exe_jump),
        .src_a_pc_i     (exe_src_a_pc),
        .src_b_imm_i    (exe_src_b_imm),
        .gpr_write_i    (exe_gpr_write),
        .rd_i           (exe_rd),
        .retire_ready_i (retire_ready_i),
        .in_ready_o     (exe_ready),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .wb_en_o        (wb_en),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data)
    );

endmodule

// ==== test/rv_model.svh ====
// rv reference model: lfsr stimulus source, random program generator and instruction set model
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

logic [15:0] lfsr_state = 16'd65388;

logic [31:0] model_pc;
logic [31:0] model_regs [16];
logic [3:0]  last_rd;

// expected retire of the latest model step
logic        m_we;
logic [3:0]  m_rd;
logic [31:0] m_data;
logic        m_redirect;
logic [31:0] m_target;
logic [31:0] m_pc;
logic        m_cf;
logic        m_dep;

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic next_random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], next_random_bit()};
    end
    return v;
endfunction

function automatic logic [31:0] random_instr();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [19:0] upper;
    logic [11:0] imm12;
    logic [6:0]  hi;
    logic [4:0]  lo;
    logic [31:0] instr;
    kind = 4'(random_bits(4));
    rd   = {1'b0, 4'(random_bits(4))};
    rs1  = {1'b0, 4'(random_bits(4))};
    rs2  = {1'b0, 4'(random_bits(4))};
    f3   = 3'(random_bits(3));
    alt  = next_random_bit();
    case (kind)
        4'd0, 4'd1, 4'd2, 4'd3: begin
            // sub and sra are the only funct7 variants
            hi    = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'd0};
            instr = {hi, rs2, rs1, f3, rd, 7'b0110011};
        end
        4'd8: instr = {20'(random_bits(20)), rd, 7'b0110111};
        4'd9: instr = {20'(random_bits(20)), rd, 7'b0010111};
        4'd10: begin
            // imm[1] cleared keeps jal targets word aligned
            upper    = 20'(random_bits(20));
            upper[9] = 1'b0;
            instr    = {upper, rd, 7'b1101111};
        end
        4'd11: instr = {12'(random_bits(12)), rs1, 3'b000, rd, 7'b1100111};
        4'd12, 4'd13, 4'd14: begin
            if (f3 == 3'b010 || f3 == 3'b011) begin
                f3 = f3 - 3'd2;
            end
            hi    = 7'(random_bits(7));
            lo    = 5'(random_bits(5));
            lo[1] = 1'b0;
            instr = {hi, rs2, rs1, f3, lo, 7'b1100011};
        end
        default: begin
            imm12 = 12'(random_bits(12));
            if (f3 == 3'b001) begin
                imm12[11:5] = 7'd0;
            end else if (f3 == 3'b101) begin
                imm12[11:5] = {1'b0, alt, 5'd0};
            end
            instr = {imm12, rs1, f3, rd, 7'b0010011};
        end
    endcase
    return instr;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input logic [31:0] x,
                                        input logic [31:0] y);
    logic signed [31:0] sx;
    logic [31:0]        r;
    sx = x;
    case (f3)
        3'b000:  r = (is_reg && alt) ? x - y : x + y;
        3'b001:  r = x << y[4:0];
        3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'b011:  r = (x < y) ? 32'd1 : 32'd0;
        3'b100:  r = x ^ y;
        3'b101: begin
            if (alt) begin
                r = sx >>> y[4:0];
            end else begin
                r = x >> y[4:0];
            end
        end
        3'b110:  r = x | y;
        default: r = x & y;
    endcase
    return r;
endfunction

// executes the instruction at model_pc and records what should retire
task automatic model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        writes;
    logic        taken;
    logic        reads_rs1;
    logic        uses_rs2;
    ins       = prog_mem[model_pc[7:2]];
    a         = model_regs[ins[18:15]];
    b         = model_regs[ins[23:20]];
    imm_i     = {{20{ins[31]}}, ins[31:20]};
    imm_b     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    writes    = 1'b1;
    taken     = 1'b0;
    reads_rs1 = 1'b1;
    uses_rs2  = 1'b0;
    m_data    = '0;
    m_target  = model_pc + imm_b;
    case (ins[6:0])
        7'b0110011: begin
            m_data   = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            uses_rs2 = 1'b1;
        end
        7'b0010011: m_data = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
        7'b0110111: begin
            m_data    = {ins[31:12], 12'd0};
            reads_rs1 = 1'b0;
        end
        7'b0010111: begin
            m_data    = model_pc + {ins[31:12], 12'd0};
            reads_rs1 = 1'b0;
        end
        7'b1101111: begin
            m_data    = model_pc + 32'd4;
            taken     = 1'b1;
            reads_rs1 = 1'b0;
            m_target  = model_pc + imm_j;
        end
        7'b1100111: begin
            m_data   = model_pc + 32'd4;
            taken    = 1'b1;
            m_target = (a + imm_i) & ~32'd1;
        end
        default: begin
            // conditional branches
            writes   = 1'b0;
            uses_rs2 = 1'b1;
            case (ins[14:12])
                3'b000:  taken = a == b;
                3'b001:  taken = a != b;
                3'b100:  taken = $signed(a) < $signed(b);
                3'b101:  taken = $signed(a) >= $signed(b);
                3'b110:  taken = a < b;
                default: taken = a >= b;
            endcase
        end
    endcase
    m_cf  = ins[6:0] == 7'b1101111 || ins[6:0] == 7'b1100111 || ins[6:0] == 7'b1100011;
    m_dep = last_rd != 4'd0 && ((reads_rs1 && ins[18:15] == last_rd) ||
                                (uses_rs2 && ins[23:20] == last_rd));
    m_pc       = model_pc;
    m_rd       = ins[10:7];
    m_we       = writes && m_rd != 4'd0;
    m_redirect = taken;
    if (m_we) begin
        model_regs[m_rd] = m_data;
    end
    last_rd  = m_we ? m_rd : 4'd0;
    model_pc = taken ? m_target : model_pc + 32'd4;
endtask

`endif

// ==== test/tb_exe_top.sv ====
// testbench for the execute subsystem: random program against an instruction set model
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_exe_top
    import rv_pkg::*;
();

    localparam int RETIRE_TARGET = 400;
    localparam int CYCLE_LIMIT   = 10 * RETIRE_TARGET + 100;

    logic                clk;
    logic                reset;
    logic                in_valid_i;
    logic [`XLEN-1:0]    pc_i;
    logic [31:0]         instr_i;
    logic                retire_ready_i;
    logic                in_ready_o;
    logic                retire_valid_o;
    logic [`XLEN-1:0]    retire_pc_o;
    logic                retire_we_o;
    logic [`REG_AW-1:0]  retire_rd_o;
    logic [`XLEN-1:0]    retire_data_o;
    logic                redirect_o;
    logic [`XLEN-1:0]    redirect_pc_o;

    logic [31:0] prog_mem [64];
    // register file rebuilt from the retire port
    logic [31:0] dut_regs [`NUM_REGS];
    logic [31:0] fetch_pc;

    // retire outputs seen in a stalled cycle
    logic        held;
    logic [31:0] h_pc;
    logic        h_we;
    logic [3:0]  h_rd;
    logic [31:0] h_data;
    logic [31:0] h_target;

    // 0 reset, 1 alu, 2 forwarding, 3 control flow, 4 back-pressure, 5 completion
    int errors [6];
    int checks [6];
    int retired;
    int cycles;
    int total;

    `include "rv_model.svh"

    exe_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .in_valid_i     (in_valid_i),
        .pc_i           (pc_i),
        .instr_i        (instr_i),
        .retire_ready_i (retire_ready_i),
        .in_ready_o     (in_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic flag_mismatch(input int cat, input string name,
                                 input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        errors[cat] = errors[cat] + 1;
    endtask

    task automatic flag_failure(input int cat, input string what);
        $display("failure at %0t: %s", $time, what);
        errors[cat] = errors[cat] + 1;
    endtask

    task automatic check_idle();
        checks[0] = checks[0] + 1;
        if (retire_valid_o !== 1'b0) begin
            flag_mismatch(0, "retire_valid_o", 32'd0, 32'(retire_valid_o));
        end
        if (redirect_o !== 1'b0) begin
            flag_mismatch(0, "redirect_o", 32'd0, 32'(redirect_o));
        end
        if (in_ready_o !== 1'b1) begin
            flag_mismatch(0, "in_ready_o", 32'd1, 32'(in_ready_o));
        end
    endtask

    task automatic drive_inputs();
        if (redirect_o === 1'b1) begin
            fetch_pc = redirect_pc_o;
        end else if (in_valid_i && in_ready_o === 1'b1) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        pc_i           <= fetch_pc;
        instr_i        <= prog_mem[fetch_pc[7:2]];
        in_valid_i     <= next_random_bit();
        retire_ready_i <= next_random_bit();
    endtask

    task automatic check_cycle();
        int cat;
        cycles = cycles + 1;
        if (held) begin
            checks[4] = checks[4] + 1;
            if (retire_valid_o !== 1'b1) begin
                flag_mismatch(4, "retire_valid_o", 32'd1, 32'(retire_valid_o));
            end
            if (retire_pc_o !== h_pc) begin
                flag_mismatch(4, "retire_pc_o", h_pc, retire_pc_o);
            end
            if (retire_we_o !== h_we) begin
                flag_mismatch(4, "retire_we_o", 32'(h_we), 32'(retire_we_o));
            end
            if (retire_rd_o !== h_rd) begin
                flag_mismatch(4, "retire_rd_o", 32'(h_rd), 32'(retire_rd_o));
            end
            if (retire_data_o !== h_data) begin
                flag_mismatch(4, "retire_data_o", h_data, retire_data_o);
            end
            if (redirect_pc_o !== h_target) begin
                flag_mismatch(4, "redirect_pc_o", h_target, redirect_pc_o);
            end
        end
        held = 1'b0;
        if (retire_valid_o === 1'b1 && retire_ready_i === 1'b0) begin
            if (in_ready_o !== 1'b0) begin
                flag_mismatch(4, "in_ready_o", 32'd0, 32'(in_ready_o));
            end
            held     = 1'b1;
            h_pc     = retire_pc_o;
            h_we     = retire_we_o;
            h_rd     = retire_rd_o;
            h_data   = retire_data_o;
            h_target = redirect_pc_o;
        end
        if (retire_valid_o === 1'b1 && retire_ready_i === 1'b1) begin
            model_step();
            cat = m_cf ? 3 : (m_dep ? 2 : 1);
            checks[cat] = checks[cat] + 1;
            if (retire_pc_o !== m_pc) begin
                flag_mismatch(cat, "retire_pc_o", m_pc, retire_pc_o);
            end
            if (retire_we_o !== m_we) begin
                flag_mismatch(cat, "retire_we_o", 32'(m_we), 32'(retire_we_o));
            end
            if (m_we && retire_rd_o !== m_rd) begin
                flag_mismatch(cat, "retire_rd_o", 32'(m_rd), 32'(retire_rd_o));
            end
            if (m_we && retire_data_o !== m_data) begin
                flag_mismatch(cat, "retire_data_o", m_data, retire_data_o);
            end
            if (redirect_o !== m_redirect) begin
                flag_mismatch(cat, "redirect_o", 32'(m_redirect), 32'(redirect_o));
            end
            if (m_redirect && redirect_pc_o !== m_target) begin
                flag_mismatch(cat, "redirect_pc_o", m_target, redirect_pc_o);
            end
            if (retire_we_o === 1'b1) begin
                dut_regs[retire_rd_o] = retire_data_o;
            end
            retired = retired + 1;
        end else if (redirect_o !== 1'b0) begin
            flag_failure(3, "redirect_o is high outside a retire handshake");
        end
    endtask

    task automatic check_final();
        checks[5] = checks[5] + 1;
        if (retired < RETIRE_TARGET) begin
            flag_failure(5, $sformatf("timeout, %0d of %0d instructions retired in %0d cycles",
                                      retired, RETIRE_TARGET, cycles));
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            if (dut_regs[r] !== model_regs[r]) begin
                flag_mismatch(5, $sformatf("retired x%0d", r), model_regs[r], dut_regs[r]);
            end
        end
    endtask

    task automatic print_test(input string name, input int cat);
        if (errors[cat] == 0) begin
            $display("test %s: ok, %0d checks", name, checks[cat]);
        end else begin
            $display("test %s: %0d errors in %0d checks", name, errors[cat], checks[cat]);
        end
    endtask

    initial begin
        reset          = 1'b1;
        in_valid_i     = 1'b0;
        pc_i           = '0;
        instr_i        = '0;
        retire_ready_i = 1'b0;
        fetch_pc       = '0;
        model_pc       = '0;
        last_rd        = 4'd0;
        held           = 1'b0;
        retired        = 0;
        cycles         = 0;
        for (int i = 0; i < 64; i++) begin
            prog_mem[i] = random_instr();
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
            dut_regs[r]   = '0;
        end

        @(posedge clk);
        @(posedge clk);
        check_idle();
        reset <= 1'b0;
        drive_inputs();
        @(posedge clk);
        check_idle();
        print_test("reset state", 0);

        while (retired < RETIRE_TARGET && cycles < CYCLE_LIMIT) begin
            check_cycle();
            drive_inputs();
            @(posedge clk);
        end

        check_final();
        print_test("alu and upper immediate results", 1);
        print_test("forwarded operands", 2);
        print_test("branches and jumps", 3);
        print_test("back-pressure", 4);
        print_test("completion and register file", 5);
        total = 0;
        for (int c = 0; c < 6; c++) begin
            total = total + errors[c];
        end
        $display("summary: %0d retired in %0d cycles, %0d errors", retired, cycles, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
+incdir+test
hw/rv_pkg.sv
hw/decode_unit.sv
hw/id_exe_reg.sv
hw/exe_unit.sv
hw/exe_top.sv
test/tb_exe_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_exe_top -f compile.f -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_exe_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
